//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word and opcodes
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_OP     = 7'b0110011;  // register-register
    localparam logic [6:0] OP_IMM    = 7'b0010011;  // register-immediate
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;  // csr and mret

    ////////////////////////////////////////////////////////////////////////////
    // control word
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SRA = 3'd7
    } alu_op_e;

    typedef enum logic [2:0] {MUL_NONE, MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;
    typedef enum logic [2:0] {DIV_NONE, DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

    typedef struct packed {
        logic beq, bne, blt, bge, bltu, bgeu;
    } br_kind_t;

    // one-hot encodings of the memory and compare selects
    localparam logic [2:0] ST_SB     = 3'b001;
    localparam logic [2:0] ST_SH     = 3'b010;
    localparam logic [2:0] ST_SW     = 3'b100;
    localparam logic [4:0] LD_LB     = 5'b00001;
    localparam logic [4:0] LD_LH     = 5'b00010;
    localparam logic [4:0] LD_LW     = 5'b00100;
    localparam logic [4:0] LD_LBU    = 5'b01000;
    localparam logic [4:0] LD_LHU    = 5'b10000;
    localparam logic [3:0] CMP_SLT   = 4'b0001;
    localparam logic [3:0] CMP_SLTU  = 4'b0010;
    localparam logic [3:0] CMP_SLTI  = 4'b0100;
    localparam logic [3:0] CMP_SLTIU = 4'b1000;

    typedef struct packed {
        alu_op_e    alu_op;
        mul_op_e    mul_op;
        div_op_e    div_op;
        br_kind_t   br_kind;
        logic [2:0] store_mask;
        logic [4:0] load_kind;
        logic [3:0] cmp_kind;
        logic branch, memread, memwrite, regwrite, alusrc, compare, auipc, lui;
        logic jal, jalr, illegal, csr_write, csr_read, trap_ret, mul_inst, div_inst;
        logic [2:0] csr_sel;        // funct3 of the system instruction
    } ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // configuration and output packet
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic m_en;
        logic zicsr_en;
    } cfg_t;

    localparam cfg_t CFG_RESET = '{m_en: 1'b1, zicsr_en: 1'b1};

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } dec_pkt_t;

endpackage

`default_nettype wire

//--- decode_cfg.sv
`timescale 1ns/1ps
`default_nettype none

// extension enables for the decoder
module decode_cfg
    import decode_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic cfg_we,
    input  cfg_t cfg_wdata,
    output cfg_t cfg
);

    // new value visible from the edge after the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= CFG_RESET;       // both extensions on
        end else if (cfg_we) begin
            cfg <= cfg_wdata;
        end
    end

    a_wdata_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        cfg_we |-> !$isunknown(cfg_wdata)
    ) else $error("cfg_wdata has unknown bits on a write");

endmodule

`default_nettype wire

//--- control.sv
`timescale 1ns/1ps
`default_nettype none

module control
    import decode_pkg::*;
(
    input  instr_t instr,
    input  cfg_t   cfg,
    input  logic   flush,
    input  logic   hazard,
    output ctrl_t  ctrl
);

    logic        stall;
    logic [11:0] funct12;

    assign funct12 = {instr.funct7, instr.rs2};
    assign stall   = flush || hazard || (instr == '0);  // zero word counts as a bubble

    ////////////////////////////////////////////////////////////////////////////
    // opcode classification
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;

        unique case (instr.opcode)
            OP_LOAD: begin
                ctrl.memread  = 1'b1;
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                unique case (instr.funct3)
                    3'b000:  ctrl.load_kind = LD_LB;
                    3'b001:  ctrl.load_kind = LD_LH;
                    3'b010:  ctrl.load_kind = LD_LW;
                    3'b100:  ctrl.load_kind = LD_LBU;
                    3'b101:  ctrl.load_kind = LD_LHU;
                    default: ctrl.illegal   = 1'b1;
                endcase
            end
            OP_OP: begin
                ctrl.regwrite = 1'b1;
                if (instr.funct7 == 7'h01) begin       // M extension
                    if (!cfg.m_en) begin
                        ctrl.illegal = 1'b1;
                    end else if (instr.funct3[2]) begin
                        ctrl.div_inst = 1'b1;
                        unique case (instr.funct3[1:0])
                            2'b00: ctrl.div_op = DIV_DIV;
                            2'b01: ctrl.div_op = DIV_DIVU;
                            2'b10: ctrl.div_op = DIV_REM;
                            2'b11: ctrl.div_op = DIV_REMU;
                        endcase
                    end else begin
                        ctrl.mul_inst = 1'b1;
                        unique case (instr.funct3[1:0])
                            2'b00: ctrl.mul_op = MUL_MUL;
                            2'b01: ctrl.mul_op = MUL_MULH;
                            2'b10: ctrl.mul_op = MUL_MULHSU;
                            2'b11: ctrl.mul_op = MUL_MULHU;
                        endcase
                    end
                end else begin
                    unique case ({instr.funct7, instr.funct3})
                        {7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
                        {7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
                        {7'h00, 3'b001}: ctrl.alu_op = ALU_SLL;
                        {7'h00, 3'b010}: begin
                            ctrl.compare  = 1'b1;
                            ctrl.cmp_kind = CMP_SLT;
                        end
                        {7'h00, 3'b011}: begin
                            ctrl.compare  = 1'b1;
                            ctrl.cmp_kind = CMP_SLTU;
                        end
                        {7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
                        {7'h00, 3'b101}: ctrl.alu_op = ALU_SRL;
                        {7'h20, 3'b101}: ctrl.alu_op = ALU_SRA;
                        {7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
                        {7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
                        default:         ctrl.illegal = 1'b1;
                    endcase
                end
            end
            OP_IMM: begin
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                unique case (instr.funct3)
                    3'b000: ctrl.alu_op = ALU_ADD;
                    3'b001: begin
                        if (instr.funct7 == 7'h00) ctrl.alu_op = ALU_SLL;
                        else ctrl.illegal = 1'b1;
                    end
                    3'b010: begin
                        ctrl.compare  = 1'b1;
                        ctrl.cmp_kind = CMP_SLTI;
                    end
                    3'b011: begin
                        ctrl.compare  = 1'b1;
                        ctrl.cmp_kind = CMP_SLTIU;
                    end
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: begin               // shamt form, funct7 picks srl/sra
                        if (instr.funct7 == 7'h00)      ctrl.alu_op = ALU_SRL;
                        else if (instr.funct7 == 7'h20) ctrl.alu_op = ALU_SRA;
                        else                            ctrl.illegal = 1'b1;
                    end
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                endcase
            end
            OP_STORE: begin
                ctrl.memwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                unique case (instr.funct3)
                    3'b000:  ctrl.store_mask = ST_SB;
                    3'b001:  ctrl.store_mask = ST_SH;
                    3'b010:  ctrl.store_mask = ST_SW;
                    default: ctrl.illegal    = 1'b1;
                endcase
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                unique case (instr.funct3)
                    3'b000:  ctrl.br_kind.beq  = 1'b1;
                    3'b001:  ctrl.br_kind.bne  = 1'b1;
                    3'b100:  ctrl.br_kind.blt  = 1'b1;
                    3'b101:  ctrl.br_kind.bge  = 1'b1;
                    3'b110:  ctrl.br_kind.bltu = 1'b1;
                    3'b111:  ctrl.br_kind.bgeu = 1'b1;
                    default: ctrl.illegal      = 1'b1;
                endcase
            end
            OP_JAL: begin
                ctrl.jal      = 1'b1;
                ctrl.regwrite = 1'b1;
            end
            OP_JALR: begin
                ctrl.jalr     = 1'b1;
                ctrl.regwrite = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                ctrl.lui      = (instr.opcode == OP_LUI);
                ctrl.auipc    = (instr.opcode == OP_AUIPC);
                ctrl.alusrc   = 1'b1;
                ctrl.regwrite = 1'b1;
            end
            OP_SYSTEM: begin
                ctrl.csr_sel = instr.funct3;
                if (instr.funct3 == 3'b000 && funct12 == 12'h302) begin
                    ctrl.trap_ret = 1'b1;       // mret, legal even without zicsr
                end else if (!cfg.zicsr_en || instr.funct3[1:0] == 2'b00) begin
                    ctrl.illegal = 1'b1;        // ecall, ebreak, reserved, or zicsr off
                end else begin
                    ctrl.alusrc    = instr.funct3[2];   // immediate forms
                    ctrl.regwrite  = 1'b1;
                    ctrl.csr_read  = 1'b1;
                    ctrl.csr_write = 1'b1;
                    if (instr.funct3[1:0] == 2'b01) begin
                        // csrrw with rd zero must not read the csr
                        if (instr.rd == 5'd0) begin
                            ctrl.regwrite = 1'b0;
                            ctrl.csr_read = 1'b0;
                        end
                    end else if (instr.rs1 == 5'd0) begin
                        ctrl.csr_write = 1'b0;  // set/clear with nothing to apply
                    end
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // architectural writes die on any stall, flow control only on flush
        if (stall) begin
            ctrl.regwrite  = 1'b0;
            ctrl.memwrite  = 1'b0;
            ctrl.csr_write = 1'b0;
            ctrl.csr_read  = 1'b0;
        end
        if (flush) begin
            ctrl.branch  = 1'b0;
            ctrl.jal     = 1'b0;
            ctrl.jalr    = 1'b0;
            ctrl.illegal = 1'b0;
        end
    end

    // select fields must never carry two hot bits
    always_comb begin
        if (!$isunknown({instr, cfg, flush, hazard})) begin
            a_br_onehot: assert ($onehot0(ctrl.br_kind))
                else $error("br_kind not one-hot: %h", ctrl.br_kind);
            a_ld_onehot: assert ($onehot0(ctrl.load_kind))
                else $error("load_kind not one-hot: %h", ctrl.load_kind);
            a_st_onehot: assert ($onehot0(ctrl.store_mask))
                else $error("store_mask not one-hot: %h", ctrl.store_mask);
        end
    end

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  instr_t      instr,
    output logic [31:0] imm
);

    logic [31:0] w;     // flat view for the bit scatter

    assign w = instr;

    always_comb begin
        unique case (instr.opcode)
            OP_LOAD, OP_IMM, OP_JALR: begin
                imm = {{20{w[31]}}, w[31:20]};
            end
            OP_STORE: begin
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {w[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_SYSTEM: begin
                // csr*i forms carry a 5-bit unsigned value in rs1
                imm = instr.funct3[2] ? {27'b0, instr.rs1} : 32'b0;
            end
            default: imm = 32'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  cfg_t     cfg,
    input  logic     instr_valid,
    input  instr_t   instr,
    input  logic     flush,
    input  logic     hazard,
    output logic     dec_valid,
    output dec_pkt_t dec
);

    ctrl_t       ctrl;
    logic [31:0] imm;

    control i_control (
        .instr  (instr),
        .cfg    (cfg),
        .flush  (flush),
        .hazard (hazard),
        .ctrl   (ctrl)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    ////////////////////////////////////////////////////////////////////////////
    // pipeline register, one cycle from strobe to packet
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= instr_valid && !flush;   // flushed slot is dropped
            if (instr_valid) begin
                dec.ctrl <= ctrl;
                dec.imm  <= imm;
                dec.rs1  <= instr.rs1;
                dec.rs2  <= instr.rs2;
                dec.rd   <= instr.rd;
            end
        end
    end

    a_flush_drops: assert property (
        @(posedge clk) disable iff (!arst_n)
        (instr_valid && flush) |=> !dec_valid
    ) else $error("flushed instruction produced dec_valid");

endmodule

`default_nettype wire

//--- decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cfg_we,
    input  cfg_t     cfg_wdata,
    input  logic     instr_valid,
    input  instr_t   instr,
    input  logic     flush,
    input  logic     hazard,
    output logic     dec_valid,
    output dec_pkt_t dec
);

    cfg_t cfg;  // current extension enables

    decode_cfg i_decode_cfg (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    decode_stage i_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .hazard      (hazard),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

endmodule

`default_nettype wire

//--- tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top
    import decode_pkg::*;
();

    localparam int RST_CYCLES = 5;
    localparam int MAX_VECS   = 64;

    typedef struct {
        logic        cfg_we;
        cfg_t        cfg_wdata;
        instr_t      instr;
        logic        hazard;
        logic        flush;
        logic        exp_valid;
        ctrl_t       ctrl;
        logic [31:0] imm;
    } vec_t;

    typedef struct {
        ctrl_t       ctrl;
        logic [31:0] imm;
        instr_t      instr;
        int          due;       // cycle on which the packet must show
        int          idx;
    } exp_t;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     cfg_we;
    cfg_t     cfg_wdata;
    logic     instr_valid;
    instr_t   instr;
    logic     flush;
    logic     hazard;
    logic     dec_valid;
    dec_pkt_t dec;

    vec_t        vt [MAX_VECS];
    int          nv = 0;
    exp_t        exp_q [$];
    int          cyc = 0;
    int          limit = 1000;
    logic [31:0] lfsr;

    decode_top i_decode_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_wdata   (cfg_wdata),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .hazard      (hazard),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    always #20 clk = ~clk;  // 40 ns period

    ////////////////////////////////////////////////////////////////////////////
    // error exit and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input int idx);
        if (got !== exp) begin
            report_fail($sformatf("[ERROR] entry %0d dec.ctrl: got %h expected %h",
                                  idx, got, exp));
        end
    endtask

    task automatic check_imm(input logic [31:0] got, input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            report_fail($sformatf("[ERROR] entry %0d dec.imm: got %h expected %h",
                                  idx, got, exp));
        end
    endtask

    task automatic check_regs(input dec_pkt_t got, input instr_t src, input int idx);
        if (got.rs1 !== src.rs1) begin
            report_fail($sformatf("[ERROR] entry %0d dec.rs1: got %h expected %h",
                                  idx, got.rs1, src.rs1));
        end
        if (got.rs2 !== src.rs2) begin
            report_fail($sformatf("[ERROR] entry %0d dec.rs2: got %h expected %h",
                                  idx, got.rs2, src.rs2));
        end
        if (got.rd !== src.rd) begin
            report_fail($sformatf("[ERROR] entry %0d dec.rd: got %h expected %h",
                                  idx, got.rd, src.rd));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoders and expected control words
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic ctrl_t reg_write_op(input alu_op_e op, input logic src);
        ctrl_t c;
        c          = '0;
        c.alu_op   = op;
        c.regwrite = 1'b1;
        c.alusrc   = src;
        return c;
    endfunction

    function automatic ctrl_t load_op(input logic [4:0] kind);
        ctrl_t c;
        c           = reg_write_op(ALU_ADD, 1'b1);
        c.memread   = 1'b1;
        c.load_kind = kind;
        return c;
    endfunction

    function automatic ctrl_t store_op(input logic [2:0] mask);
        ctrl_t c;
        c            = '0;
        c.memwrite   = 1'b1;
        c.alusrc     = 1'b1;
        c.store_mask = mask;
        return c;
    endfunction

    function automatic ctrl_t csr_op(input logic [2:0] sel);
        ctrl_t c;
        c         = '0;
        c.csr_sel = sel;
        return c;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // vector table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_vec(input instr_t i, input ctrl_t c, input logic [31:0] imm);
        vt[nv].cfg_we    = 1'b0;
        vt[nv].cfg_wdata = CFG_RESET;
        vt[nv].instr     = i;
        vt[nv].hazard    = 1'b0;
        vt[nv].flush     = 1'b0;
        vt[nv].exp_valid = 1'b1;
        vt[nv].ctrl      = c;
        vt[nv].imm       = imm;
        nv = nv + 1;
    endtask

    task automatic set_cfg_write(input cfg_t v);
        vt[nv-1].cfg_we    = 1'b1;
        vt[nv-1].cfg_wdata = v;
    endtask

    task automatic build_table();
        ctrl_t c;
        // register and immediate arithmetic
        add_vec(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), reg_write_op(ALU_ADD, 1'b0), 32'h0);
        add_vec(enc_r(7'h20, 5'd7, 5'd6, 3'b000, 5'd5), reg_write_op(ALU_SUB, 1'b0), 32'h0);
        add_vec(enc_r(7'h20, 5'd10, 5'd9, 3'b101, 5'd8), reg_write_op(ALU_SRA, 1'b0), 32'h0);
        add_vec(enc_r(7'h00, 5'd16, 5'd15, 3'b110, 5'd14), reg_write_op(ALU_OR, 1'b0), 32'h0);
        c = reg_write_op(ALU_ADD, 1'b0);
        c.compare  = 1'b1;
        c.cmp_kind = CMP_SLT;
        add_vec(enc_r(7'h00, 5'd13, 5'd12, 3'b010, 5'd11), c, 32'h0);
        add_vec(enc_i(12'hffb, 5'd2, 3'b000, 5'd1, OP_IMM), reg_write_op(ALU_ADD, 1'b1),
                32'hffff_fffb);
        add_vec(enc_i(12'h407, 5'd4, 3'b101, 5'd3, OP_IMM), reg_write_op(ALU_SRA, 1'b1),
                32'h0000_0407);
        add_vec(enc_i(12'h01f, 5'd10, 3'b001, 5'd9, OP_IMM), reg_write_op(ALU_SLL, 1'b1),
                32'h0000_001f);
        add_vec(enc_i(12'h7ff, 5'd8, 3'b111, 5'd7, OP_IMM), reg_write_op(ALU_AND, 1'b1),
                32'h0000_07ff);
        c = reg_write_op(ALU_ADD, 1'b1);
        c.compare  = 1'b1;
        c.cmp_kind = CMP_SLTIU;
        add_vec(enc_i(12'h064, 5'd6, 3'b011, 5'd5, OP_IMM), c, 32'h0000_0064);
        c = reg_write_op(ALU_ADD, 1'b1);
        c.lui = 1'b1;
        add_vec(enc_u(20'hfffff, 5'd9, OP_LUI), c, 32'hffff_f000);
        c = reg_write_op(ALU_ADD, 1'b1);
        c.auipc = 1'b1;
        add_vec(enc_u(20'h12345, 5'd10, OP_AUIPC), c, 32'h1234_5000);
        // loads and stores, one per width
        add_vec(enc_i(12'hfff, 5'd2, 3'b000, 5'd1, OP_LOAD), load_op(LD_LB), 32'hffff_ffff);
        add_vec(enc_i(12'h002, 5'd4, 3'b001, 5'd3, OP_LOAD), load_op(LD_LH), 32'h0000_0002);
        add_vec(enc_i(12'h010, 5'd6, 3'b010, 5'd5, OP_LOAD), load_op(LD_LW), 32'h0000_0010);
        add_vec(enc_i(12'h800, 5'd8, 3'b100, 5'd7, OP_LOAD), load_op(LD_LBU), 32'hffff_f800);
        add_vec(enc_i(12'h7ff, 5'd10, 3'b101, 5'd9, OP_LOAD), load_op(LD_LHU), 32'h0000_07ff);
        add_vec(enc_s(12'hff8, 5'd5, 5'd6, 3'b010), store_op(ST_SW), 32'hffff_fff8);
        add_vec(enc_s(12'h003, 5'd7, 5'd8, 3'b000), store_op(ST_SB), 32'h0000_0003);
        c = store_op(ST_SH);
        c.memwrite = 1'b0;      // bubble keeps the mask
        add_vec(enc_s(12'hc18, 5'd9, 5'd10, 3'b001), c, 32'hffff_fc18);
        vt[nv-1].hazard = 1'b1;
        // branches and jumps
        c = csr_op(3'b000);
        c.branch = 1'b1;
        c.br_kind.beq = 1'b1;
        add_vec(enc_b(13'h1ff0, 5'd2, 5'd1, 3'b000), c, 32'hffff_fff0);
        c.br_kind = '0;
        c.br_kind.bne = 1'b1;
        add_vec(enc_b(13'h0008, 5'd4, 5'd3, 3'b001), c, 32'h0000_0008);
        c.br_kind = '0;
        c.br_kind.blt = 1'b1;
        add_vec(enc_b(13'h1000, 5'd6, 5'd5, 3'b100), c, 32'hffff_f000);
        c.br_kind = '0;
        c.br_kind.bge = 1'b1;
        add_vec(enc_b(13'h0ffe, 5'd8, 5'd7, 3'b101), c, 32'h0000_0ffe);
        c.br_kind = '0;
        c.br_kind.bltu = 1'b1;
        add_vec(enc_b(13'h0800, 5'd10, 5'd9, 3'b110), c, 32'h0000_0800);
        c.br_kind = '0;
        c.br_kind.bgeu = 1'b1;
        add_vec(enc_b(13'h1ffe, 5'd12, 5'd11, 3'b111), c, 32'hffff_fffe);
        c.br_kind = '0;
        c.illegal = 1'b1;       // reserved funct3
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b010), c, 32'h0000_0010);
        c = csr_op(3'b000);
        c.jal      = 1'b1;
        c.regwrite = 1'b1;
        add_vec(enc_j(21'h1ffffc, 5'd1), c, 32'hffff_fffc);
        add_vec(enc_j(21'h04aee8, 5'd3), c, 32'h0004_aee8);
        c = csr_op(3'b000);
        c.jalr     = 1'b1;
        c.regwrite = 1'b1;
        add_vec(enc_i(12'h00c, 5'd5, 3'b000, 5'd1, OP_JALR), c, 32'h0000_000c);
        c = load_op(5'b0);
        c.illegal = 1'b1;
        add_vec(enc_i(12'h004, 5'd2, 3'b011, 5'd1, OP_LOAD), c, 32'h0000_0004);
        // stall cases
        c = reg_write_op(ALU_ADD, 1'b1);
        c.regwrite = 1'b0;
        add_vec(enc_i(12'h001, 5'd2, 3'b000, 5'd1, OP_IMM), c, 32'h0000_0001);
        vt[nv-1].hazard = 1'b1;
        add_vec(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), '0, 32'h0);
        vt[nv-1].flush     = 1'b1;
        vt[nv-1].exp_valid = 1'b0;
        c = csr_op(3'b000);
        c.illegal = 1'b1;
        add_vec('0, c, 32'h0);
        // csr and mret
        c = csr_op(3'b001);
        c.csr_write = 1'b1;
        add_vec(enc_i(12'h300, 5'd5, 3'b001, 5'd0, OP_SYSTEM), c, 32'h0);
        c = csr_op(3'b010);
        c.regwrite = 1'b1;
        c.csr_read = 1'b1;
        add_vec(enc_i(12'h300, 5'd0, 3'b010, 5'd6, OP_SYSTEM), c, 32'h0);
        c = csr_op(3'b101);
        c.alusrc    = 1'b1;
        c.regwrite  = 1'b1;
        c.csr_read  = 1'b1;
        c.csr_write = 1'b1;
        add_vec(enc_i(12'h305, 5'd21, 3'b101, 5'd7, OP_SYSTEM), c, 32'h0000_0015);
        c = csr_op(3'b000);
        c.trap_ret = 1'b1;
        add_vec(enc_i(12'h302, 5'd0, 3'b000, 5'd0, OP_SYSTEM), c, 32'h0);
        // extension enables, a write lands after its own strobe
        c = reg_write_op(ALU_ADD, 1'b0);
        c.mul_inst = 1'b1;
        c.mul_op   = MUL_MUL;
        add_vec(enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd1), c, 32'h0);
        set_cfg_write(cfg_t'{m_en: 1'b0, zicsr_en: 1'b1});
        c = reg_write_op(ALU_ADD, 1'b0);
        c.illegal = 1'b1;
        add_vec(enc_r(7'h01, 5'd6, 5'd5, 3'b011, 5'd4), c, 32'h0);
        add_vec(enc_r(7'h01, 5'd9, 5'd8, 3'b100, 5'd7), c, 32'h0);
        c = csr_op(3'b001);
        c.regwrite  = 1'b1;
        c.csr_read  = 1'b1;
        c.csr_write = 1'b1;
        add_vec(enc_i(12'h340, 5'd2, 3'b001, 5'd1, OP_SYSTEM), c, 32'h0);
        set_cfg_write(cfg_t'{m_en: 1'b1, zicsr_en: 1'b0});
        c = csr_op(3'b001);
        c.illegal = 1'b1;
        add_vec(enc_i(12'h340, 5'd3, 3'b001, 5'd2, OP_SYSTEM), c, 32'h0);
        c = csr_op(3'b000);
        c.trap_ret = 1'b1;
        add_vec(enc_i(12'h302, 5'd0, 3'b000, 5'd0, OP_SYSTEM), c, 32'h0);
        c = reg_write_op(ALU_ADD, 1'b0);
        c.div_inst = 1'b1;
        c.div_op   = DIV_REMU;
        add_vec(enc_r(7'h01, 5'd5, 5'd4, 3'b111, 5'd3), c, 32'h0);
        c = reg_write_op(ALU_ADD, 1'b0);
        c.mul_inst = 1'b1;
        c.mul_op   = MUL_MULH;
        add_vec(enc_r(7'h01, 5'd8, 5'd7, 3'b001, 5'd6), c, 32'h0);
        set_cfg_write(CFG_RESET);
        c = csr_op(3'b011);
        c.regwrite  = 1'b1;
        c.csr_read  = 1'b1;
        c.csr_write = 1'b1;
        add_vec(enc_i(12'h300, 5'd10, 3'b011, 5'd9, OP_SYSTEM), c, 32'h0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_idle();
        instr_valid = 1'b0;
        instr       = '0;
        cfg_we      = 1'b0;
        flush       = 1'b0;
        hazard      = 1'b0;
    endtask

    task automatic drive_entry(input int k);
        exp_t e;
        instr_valid = 1'b1;
        instr       = vt[k].instr;
        hazard      = vt[k].hazard;
        flush       = vt[k].flush;
        cfg_we      = vt[k].cfg_we;
        cfg_wdata   = vt[k].cfg_wdata;
        if (vt[k].exp_valid) begin
            e.ctrl  = vt[k].ctrl;
            e.imm   = vt[k].imm;
            e.instr = vt[k].instr;
            e.due   = cyc + 1;      // registered at the next edge
            e.idx   = k;
            exp_q.push_back(e);
        end
    endtask

    task automatic draw_gap(output int g);
        g = 0;
        for (int b = 0; b < 2; b++) begin
            if (lfsr[0]) g = g + (1 << b);
            lfsr = lfsr_next(lfsr);     // one step per bit
        end
    endtask

    initial begin
        int gap;
        arst_n    = 1'b0;
        cfg_wdata = CFG_RESET;
        drive_idle();
        lfsr = 32'h1de5_7cd5;
        build_table();
        limit = RST_CYCLES + nv * 5;
        repeat (RST_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int k = 0; k < nv; k++) begin
            @(posedge clk);
            #2 drive_entry(k);
            draw_gap(gap);
            repeat (gap) begin
                @(posedge clk);
                #2 drive_idle();
            end
        end
        @(posedge clk);
        #2 drive_idle();
        repeat (3) @(posedge clk);
        if (exp_q.size() != 0) begin
            report_fail($sformatf("%0d expected packets never appeared", exp_q.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // monitor, samples registered outputs at the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        exp_t e;
        if (cyc > limit) begin
            report_fail($sformatf("timeout: run went past %0d cycles", limit));
        end
        if (dec_valid) begin
            if (exp_q.size() == 0) begin
                report_fail("dec_valid seen while no packet was expected");
            end
            e = exp_q.pop_front();
            if (e.due != cyc) begin
                report_fail($sformatf("entry %0d arrived on cycle %0d instead of %0d",
                                      e.idx, cyc, e.due));
            end
            check_ctrl(dec.ctrl, e.ctrl, e.idx);
            check_imm(dec.imm, e.imm, e.idx);
            check_regs(dec, e.instr, e.idx);
        end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            report_fail($sformatf("entry %0d produced no dec_valid", exp_q[0].idx));
        end
        cyc = cyc + 1;
    end

endmodule

`default_nettype wire

//--- compile.f
decode_pkg.sv
decode_cfg.sv
control.sv
imm_gen.sv
decode_stage.sv
decode_top.sv
tb_decode_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_decode_top -o sim_decode && \
./obj_dir/sim_decode || exit 1
